// File: cpu_pkg.sv
/* decode-execute core types and encodings */

package cpu_pkg;

	localparam int WORD_W   = 32;
	localparam int NUM_REGS = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [4:0]        regbits_t;

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDIU = 6'h09,
		SLTI  = 6'h0a,
		ANDI  = 6'h0c,
		ORI   = 6'h0d,
		XORI  = 6'h0e,
		LUI   = 6'h0f,
		HALT  = 6'h3f
	} opcode_t;

	// r-type funct codes, instr[5:0]
	typedef enum logic [5:0] {
		SLL  = 6'h00,
		SRL  = 6'h02,
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		SLT  = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} aluop_t;

	typedef enum logic {
		SRC_REG = 1'b0,
		SRC_IMM = 1'b1
	} alu_src_t;

	typedef struct packed {
		logic     valid;
		logic     wen;
		logic     halt;
		logic     branch;
		logic     bne;
		aluop_t   alu_op;
		alu_src_t alu_src;
		regbits_t rs;
		regbits_t rt;
		regbits_t dest;
		word_t    rdat1;
		word_t    rdat2;
		word_t    imm_ext;
		logic [4:0] shamt;
		word_t    instr_addr;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		logic     wen;
		regbits_t dest;
		word_t    result;
		logic     halt;
	} ex_wb_t;

	// inactive slots, loaded on reset and flush
	localparam id_ex_t ID_EX_BUBBLE = '{
		valid: 1'b0, wen: 1'b0, halt: 1'b0, branch: 1'b0, bne: 1'b0,
		alu_op: ALU_ADD, alu_src: SRC_REG,
		rs: '0, rt: '0, dest: '0,
		rdat1: '0, rdat2: '0, imm_ext: '0, shamt: '0, instr_addr: '0
	};

	localparam ex_wb_t EX_WB_BUBBLE = '{
		valid: 1'b0, wen: 1'b0, dest: '0, result: '0, halt: 1'b0
	};

endpackage

// File: decoder.sv
/* instruction decoder */

`timescale 1ns/1ps

module decoder import cpu_pkg::*; (
	input  word_t    instr,
	input  word_t    instr_addr,
	input  logic     instr_valid,
	input  word_t    rdat1,
	input  word_t    rdat2,
	output regbits_t rs,
	output regbits_t rt,
	output id_ex_t   id_out
);

	opcode_t  opcode;
	funct_t   funct;
	regbits_t rd;
	word_t    imm_sext;
	word_t    imm_zext;

	// instruction fields
	assign opcode   = opcode_t'(instr[31:26]);
	assign funct    = funct_t'(instr[5:0]);
	assign rs       = instr[25:21];
	assign rt       = instr[20:16];
	assign rd       = instr[15:11];
	assign imm_sext = {{16{instr[15]}}, instr[15:0]};
	assign imm_zext = {16'h0000, instr[15:0]};

	always_comb begin
		id_out            = ID_EX_BUBBLE;
		id_out.valid      = instr_valid;
		id_out.rs         = rs;
		id_out.rt         = rt;
		id_out.dest       = rt;
		id_out.rdat1      = rdat1;
		id_out.rdat2      = rdat2;
		id_out.imm_ext    = imm_sext;
		id_out.shamt      = instr[10:6];
		id_out.instr_addr = instr_addr;

		case (opcode)
			RTYPE: begin
				id_out.dest = rd;
				id_out.wen  = 1'b1;
				case (funct)
					ADDU: id_out.alu_op = ALU_ADD;
					SUBU: id_out.alu_op = ALU_SUB;
					AND:  id_out.alu_op = ALU_AND;
					OR:   id_out.alu_op = ALU_OR;
					XOR:  id_out.alu_op = ALU_XOR;
					SLT:  id_out.alu_op = ALU_SLT;
					SLL:  id_out.alu_op = ALU_SLL;
					SRL:  id_out.alu_op = ALU_SRL;
					// unknown funct retires as a no-op
					default: id_out.wen = 1'b0;
				endcase
			end
			ADDIU, SLTI: begin
				id_out.wen     = 1'b1;
				id_out.alu_src = SRC_IMM;
				id_out.alu_op  = (opcode == SLTI) ? ALU_SLT : ALU_ADD;
			end
			ANDI, ORI, XORI, LUI: begin
				id_out.wen     = 1'b1;
				id_out.alu_src = SRC_IMM;
				id_out.imm_ext = imm_zext;
				case (opcode)
					ANDI:    id_out.alu_op = ALU_AND;
					ORI:     id_out.alu_op = ALU_OR;
					XORI:    id_out.alu_op = ALU_XOR;
					default: id_out.alu_op = ALU_LUI;
				endcase
			end
			BEQ, BNE: begin
				id_out.branch = 1'b1;
				id_out.bne    = (opcode == BNE);
				id_out.alu_op = ALU_SUB;
			end
			HALT: id_out.halt = 1'b1;
			default: ;
		endcase

		// r0 is never a real destination
		if (id_out.dest == '0)
			id_out.wen = 1'b0;
	end

endmodule

// File: register_file.sv
/* register file, write-through */

`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     wen,
	input  regbits_t wsel,
	input  word_t    wdat,
	input  regbits_t rsel1,
	input  regbits_t rsel2,
	output word_t    rdat1,
	output word_t    rdat2
);

	word_t regs [NUM_REGS];
	logic  wr_live;

	// r0 writes are dropped
	assign wr_live = wen && (wsel != '0);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_live) begin
			regs[wsel] <= wdat;
		end
	end

	// same-cycle write is visible to decode
	always_comb begin
		if (rsel1 == '0)
			rdat1 = '0;
		else if (wr_live && (wsel == rsel1))
			rdat1 = wdat;
		else
			rdat1 = regs[rsel1];

		if (rsel2 == '0)
			rdat2 = '0;
		else if (wr_live && (wsel == rsel2))
			rdat2 = wdat;
		else
			rdat2 = regs[rsel2];
	end

endmodule

// File: pipe_reg.sv
/* pipeline stage register */

`timescale 1ns/1ps

module pipe_reg #(
	parameter type      payload_t = logic,
	parameter payload_t BUBBLE    = '0
) (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     enable,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	payload_t q_nxt;

	// flush wins over enable, otherwise hold
	always_comb begin
		q_nxt = q;
		if (flush)
			q_nxt = BUBBLE;
		else if (enable)
			q_nxt = d;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			q <= BUBBLE;
		else
			q <= q_nxt;
	end

endmodule

// File: alu.sv
/* arithmetic logic unit */

`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  aluop_t     op,
	input  word_t      a,
	input  word_t      b,
	input  logic [4:0] shamt,
	output word_t      result,
	output logic       zero
);

	word_t diff;

	assign diff = a - b;

	// branch compare uses equality of the raw operands
	assign zero = (a == b);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = diff;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			// signed compare from the sign of the difference and overflow
			ALU_SLT: begin
				if (a[31] != b[31])
					result = {31'b0, a[31]};
				else
					result = {31'b0, diff[31]};
			end
			ALU_SLL: result = b << shamt;
			ALU_SRL: result = b >> shamt;
			ALU_LUI: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

endmodule

// File: hazard_unit.sv
/* forwarding and pipeline control */

`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
	input  logic     accept,
	input  logic     stall,
	input  logic     branch_taken,
	input  regbits_t ex_rs,
	input  regbits_t ex_rt,
	input  logic     wb_wen,
	input  regbits_t wb_dest,
	output logic     fwd_a,
	output logic     fwd_b,
	output logic     id_ex_en,
	output logic     id_ex_flush,
	output logic     ex_wb_en
);

	logic wb_live;

	// only a real write to a nonzero register forwards
	assign wb_live = wb_wen && (wb_dest != '0);

	assign fwd_a = wb_live && (wb_dest == ex_rs);
	assign fwd_b = wb_live && (wb_dest == ex_rt);

	// stall freezes both stages
	assign id_ex_en = !stall;
	assign ex_wb_en = !stall;

	// squash the slot behind a taken branch, or fill an empty decode slot
	assign id_ex_flush = branch_taken || (!accept && !stall);

endmodule

// File: exec_core.sv
/* decode-execute pipeline top */

`timescale 1ns/1ps

module exec_core import cpu_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  word_t    instr,
	input  word_t    instr_addr,
	input  logic     instr_valid,
	input  logic     stall,
	output logic     wb_en,
	output regbits_t wb_reg,
	output word_t    wb_data,
	output logic     branch_taken,
	output word_t    branch_target,
	output logic     halted
);

	regbits_t rs, rt;
	word_t    rdat1, rdat2;
	id_ex_t   id_pl, ex;
	ex_wb_t   ex_out, wb;
	logic     accept;
	logic     fwd_a, fwd_b;
	logic     id_ex_en, id_ex_flush, ex_wb_en;
	word_t    op_a, op_b_reg, op_b;
	word_t    alu_result;
	logic     alu_zero;

	assign accept = instr_valid && !stall && !halted;

	decoder u_decoder (
		.instr(instr), .instr_addr(instr_addr), .instr_valid(instr_valid),
		.rdat1(rdat1), .rdat2(rdat2), .rs(rs), .rt(rt), .id_out(id_pl)
	);

	register_file u_regfile (
		.CLK(CLK), .nRST(nRST),
		.wen(wb_en), .wsel(wb.dest), .wdat(wb.result),
		.rsel1(rs), .rsel2(rt), .rdat1(rdat1), .rdat2(rdat2)
	);

	pipe_reg #(.payload_t(id_ex_t), .BUBBLE(ID_EX_BUBBLE)) u_id_ex (
		.CLK(CLK), .nRST(nRST), .enable(id_ex_en), .flush(id_ex_flush),
		.d(id_pl), .q(ex)
	);

	hazard_unit u_hazard (
		.accept(accept), .stall(stall), .branch_taken(branch_taken),
		.ex_rs(ex.rs), .ex_rt(ex.rt), .wb_wen(wb_en), .wb_dest(wb.dest),
		.fwd_a(fwd_a), .fwd_b(fwd_b),
		.id_ex_en(id_ex_en), .id_ex_flush(id_ex_flush), .ex_wb_en(ex_wb_en)
	);

	// operand forwarding from ex/wb
	assign op_a     = fwd_a ? wb.result : ex.rdat1;
	assign op_b_reg = fwd_b ? wb.result : ex.rdat2;
	assign op_b     = (ex.alu_src == SRC_IMM) ? ex.imm_ext : op_b_reg;

	alu u_alu (
		.op(ex.alu_op), .a(op_a), .b(op_b), .shamt(ex.shamt),
		.result(alu_result), .zero(alu_zero)
	);

	// no branch decision while frozen
	assign branch_taken  = ex.valid && ex.branch && !stall && (alu_zero != ex.bne);
	assign branch_target = ex.instr_addr + 32'd4 + {ex.imm_ext[29:0], 2'b00};

	always_comb begin
		ex_out        = EX_WB_BUBBLE;
		ex_out.valid  = ex.valid;
		ex_out.wen    = ex.valid && ex.wen;
		ex_out.dest   = ex.dest;
		ex_out.result = alu_result;
		ex_out.halt   = ex.valid && ex.halt;
	end

	// ex/wb is never flushed
	pipe_reg #(.payload_t(ex_wb_t), .BUBBLE(EX_WB_BUBBLE)) u_ex_wb (
		.CLK(CLK), .nRST(nRST), .enable(ex_wb_en), .flush(1'b0),
		.d(ex_out), .q(wb)
	);

	assign wb_en   = wb.valid && wb.wen;
	assign wb_reg  = wb.dest;
	assign wb_data = wb.result;

	// sticky halt
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			halted <= 1'b0;
		else if (wb.valid && wb.halt)
			halted <= 1'b1;
	end

endmodule

// File: exec_checker.sv
/* reference model and retire checker */

`timescale 1ns/1ps

module exec_checker import cpu_pkg::*; (
	input  logic         CLK,
	input  logic         nRST,
	input  word_t        instr,
	input  word_t        instr_addr,
	input  logic         instr_valid,
	input  logic         stall,
	input  logic [127:0] test_name,
	input  logic         wb_en,
	input  regbits_t     wb_reg,
	input  word_t        wb_data,
	input  logic         branch_taken,
	input  word_t        branch_target,
	input  logic         halted,
	output int           pass_cnt,
	output int           fail_cnt,
	output int           outstanding
);

	word_t        model_regs [NUM_REGS];
	logic [127:0] exp_name [$];
	regbits_t     exp_reg [$];
	word_t        exp_data [$];
	int           exp_due [$];
	int           adv;
	logic         br_pend;
	logic         br_exp_taken;
	word_t        br_exp_target;
	logic [127:0] br_name;
	logic         skip_next;
	logic         halt_exp;
	logic         halt_seen;

	initial begin
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		outstanding = 0;
		adv         = 0;
		br_pend     = 1'b0;
		skip_next   = 1'b0;
		halt_exp    = 1'b0;
		halt_seen   = 1'b0;
	end

	task automatic check_retire();
		if (exp_reg.size() == 0) begin
			$display("unexpected retire of r%0d with %h", wb_reg, wb_data);
			fail_cnt++;
		end else begin
			if (wb_reg != exp_reg[0] || wb_data != exp_data[0]) begin
				$display("** Error %0s: expected r%0d=%h, actual r%0d=%h",
					exp_name[0], exp_reg[0], exp_data[0], wb_reg, wb_data);
				fail_cnt++;
			end else if (adv != exp_due[0]) begin
				$display("%0s retired r%0d=%h at the wrong cycle",
					exp_name[0], wb_reg, wb_data);
				fail_cnt++;
			end else begin
				$display("%0s ok, r%0d=%h", exp_name[0], wb_reg, wb_data);
				pass_cnt++;
			end
			void'(exp_name.pop_front());
			void'(exp_reg.pop_front());
			void'(exp_data.pop_front());
			void'(exp_due.pop_front());
		end
	endtask

	task automatic check_branch();
		if (branch_taken != br_exp_taken) begin
			$display("** Error %0s: expected taken=%b, actual taken=%b",
				br_name, br_exp_taken, branch_taken);
			fail_cnt++;
		end else if (br_exp_taken && branch_target != br_exp_target) begin
			$display("** Error %0s: expected target=%h, actual target=%h",
				br_name, br_exp_target, branch_target);
			fail_cnt++;
		end else begin
			$display("%0s ok, taken=%b", br_name, branch_taken);
			pass_cnt++;
		end
		skip_next = br_exp_taken;
		br_pend   = 1'b0;
	endtask

	// architectural model of one instruction in program order
	task automatic accept_instr();
		logic [5:0]  op;
		logic [5:0]  fn;
		regbits_t    rs;
		regbits_t    rt;
		regbits_t    dest;
		word_t       a;
		word_t       b;
		word_t       sext;
		word_t       zext;
		word_t       res;
		logic        wr;
		op   = instr[31:26];
		fn   = instr[5:0];
		rs   = instr[25:21];
		rt   = instr[20:16];
		a    = model_regs[rs];
		b    = model_regs[rt];
		sext = {{16{instr[15]}}, instr[15:0]};
		zext = {16'h0000, instr[15:0]};
		dest = rt;
		res  = '0;
		wr   = 1'b1;
		case (op)
			6'h00: begin
				dest = instr[15:11];
				case (fn)
					6'h21: res = a + b;
					6'h23: res = a - b;
					6'h24: res = a & b;
					6'h25: res = a | b;
					6'h26: res = a ^ b;
					6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					6'h00: res = b << instr[10:6];
					6'h02: res = b >> instr[10:6];
					default: wr = 1'b0;
				endcase
			end
			6'h09: res = a + sext;
			6'h0a: res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
			6'h0c: res = a & zext;
			6'h0d: res = a | zext;
			6'h0e: res = a ^ zext;
			6'h0f: res = {instr[15:0], 16'h0000};
			default: wr = 1'b0;
		endcase
		if (skip_next) begin
			$display("%0s ok, squashed by taken branch", test_name);
			pass_cnt++;
			skip_next = 1'b0;
		end else if (op == 6'h04 || op == 6'h05) begin
			br_pend       = 1'b1;
			br_name       = test_name;
			br_exp_taken  = (op == 6'h04) ? (a == b) : (a != b);
			br_exp_target = instr_addr + 32'd4 + (sext << 2);
		end else if (op == 6'h3f) begin
			halt_exp = 1'b1;
		end else if (wr && dest != '0) begin
			model_regs[dest] = res;
			exp_name.push_back(test_name);
			exp_reg.push_back(dest);
			exp_data.push_back(res);
			// retire two advancing edges after acceptance
			exp_due.push_back(adv + 2);
		end else begin
			$display("%0s ok, no retire expected", test_name);
			pass_cnt++;
		end
	endtask

	always @(posedge CLK) begin
		if (nRST) begin
			// stalled edges move nothing down the pipeline
			if (!stall)
				adv++;
			if (!stall && wb_en)
				check_retire();
			if (!stall && br_pend)
				check_branch();
			else if (branch_taken) begin
				$display("branch_taken raised with no branch due in EX");
				fail_cnt++;
			end
			if (halted && !halt_seen) begin
				halt_seen = 1'b1;
				if (halt_exp) begin
					$display("halt ok, halted is set");
					pass_cnt++;
				end else begin
					$display("halted rose without a halt instruction");
					fail_cnt++;
				end
			end
			if (instr_valid && !stall && !halted)
				accept_instr();
			else begin
				skip_next = 1'b0;
				if (instr_valid && !stall && halted) begin
					$display("%0s ok, ignored after halt", test_name);
					pass_cnt++;
				end
			end
		end
		outstanding = exp_reg.size();
	end

endmodule

// File: exec_core_props.sv
/* pipeline assertions */

`timescale 1ns/1ps

module exec_core_props import cpu_pkg::*; (
	input logic     CLK,
	input logic     nRST,
	input logic     stall,
	input logic     wb_en,
	input regbits_t wb_reg,
	input logic     branch_taken,
	input logic     halted
);

	no_r0_retire: assert property (@(posedge CLK) disable iff (!nRST)
		wb_en |-> (wb_reg != '0))
		else $error("retire to register 0");

	halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		!$fell(halted))
		else $error("halted fell");

	// frozen pipeline makes no branch decision
	no_branch_in_stall: assert property (@(posedge CLK) disable iff (!nRST)
		branch_taken |-> !stall)
		else $error("branch taken during stall");

	quiet_after_reset: assert property (@(posedge CLK)
		$rose(nRST) |-> !wb_en)
		else $error("retire right after reset");

endmodule

bind exec_core exec_core_props u_props (
	.CLK(CLK), .nRST(nRST), .stall(stall), .wb_en(wb_en), .wb_reg(wb_reg),
	.branch_taken(branch_taken), .halted(halted)
);

// File: tb_exec_core.sv
/* decode-execute core testbench */

`timescale 1ns/1ps

module tb_exec_core import cpu_pkg::*; ();

	logic         CLK;
	logic         nRST;
	word_t        instr;
	word_t        instr_addr;
	logic         instr_valid;
	logic         stall;
	logic [127:0] cur_name;
	logic         wb_en;
	regbits_t     wb_reg;
	word_t        wb_data;
	logic         branch_taken;
	word_t        branch_target;
	logic         halted;
	int           pass_cnt;
	int           fail_cnt;
	int           outstanding;

	// stimulus table
	logic [127:0] tbl_name [32];
	word_t        tbl_instr [32];
	logic         tbl_stall [32];
	string        tbl_note [32];
	int           num_entries;
	int           cur_entry;
	int           cycles;
	int           limit;
	int           extra_fail;
	logic [31:0]  rng;

	exec_core DUT (
		.CLK(CLK), .nRST(nRST), .instr(instr), .instr_addr(instr_addr),
		.instr_valid(instr_valid), .stall(stall), .wb_en(wb_en), .wb_reg(wb_reg),
		.wb_data(wb_data), .branch_taken(branch_taken),
		.branch_target(branch_target), .halted(halted)
	);

	exec_checker u_checker (
		.CLK(CLK), .nRST(nRST), .instr(instr), .instr_addr(instr_addr),
		.instr_valid(instr_valid), .stall(stall), .test_name(cur_name),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.halted(halted), .pass_cnt(pass_cnt), .fail_cnt(fail_cnt),
		.outstanding(outstanding)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t enc_r(input regbits_t rs, input regbits_t rt,
			input regbits_t rd, input logic [4:0] sh, input funct_t fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t enc_i(input opcode_t op, input regbits_t rs,
			input regbits_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic add_entry(input logic [127:0] nm, input word_t iw, input logic st,
			input string note);
		tbl_name[num_entries]  = nm;
		tbl_instr[num_entries] = iw;
		tbl_stall[num_entries] = st;
		tbl_note[num_entries]  = note;
		num_entries++;
	endtask

	task automatic idle_cycle();
		@(negedge CLK);
		instr_valid = 1'b0;
		stall       = 1'b0;
	endtask

	// tight entries follow a branch, so no gap and no stall
	task automatic drive_entry(input int i, input logic tight);
		int gap;
		int nstall;
		rng    = xorshift(rng);
		gap    = tight ? 0 : int'(rng % 2);
		rng    = xorshift(rng);
		nstall = (tbl_stall[i] && !tight) ? 1 + int'(rng % 2) : 0;
		repeat (gap)
			idle_cycle();
		cur_entry = i;
		repeat (nstall) begin
			@(negedge CLK);
			cur_name    = tbl_name[i];
			instr       = tbl_instr[i];
			instr_addr  = 32'h0000_1000 + 32'(4 * i);
			instr_valid = 1'b1;
			stall       = 1'b1;
		end
		@(negedge CLK);
		cur_name    = tbl_name[i];
		instr       = tbl_instr[i];
		instr_addr  = 32'h0000_1000 + 32'(4 * i);
		instr_valid = 1'b1;
		stall       = 1'b0;
	endtask

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	initial begin
		num_entries = 0;
		add_entry("addiu_pos", enc_i(ADDIU, 5'd0, 5'd1, 16'd5), 1'b0, "r1 = 5");
		add_entry("addiu_neg", enc_i(ADDIU, 5'd0, 5'd2, 16'hfffd), 1'b0, "r2 = -3");
		add_entry("addu_fwd", enc_r(5'd1, 5'd2, 5'd3, 5'd0, ADDU), 1'b0, "forward r2");
		add_entry("subu", enc_r(5'd1, 5'd2, 5'd4, 5'd0, SUBU), 1'b0, "5 - -3");
		add_entry("and", enc_r(5'd3, 5'd4, 5'd5, 5'd0, AND), 1'b0, "r3 & r4");
		add_entry("or_stall", enc_r(5'd1, 5'd4, 5'd6, 5'd0, OR), 1'b1, "stalled or");
		add_entry("xor", enc_r(5'd6, 5'd2, 5'd7, 5'd0, XOR), 1'b0, "r6 ^ r2");
		add_entry("slt", enc_r(5'd2, 5'd1, 5'd8, 5'd0, SLT), 1'b0, "signed, 1");
		add_entry("sll", enc_r(5'd0, 5'd1, 5'd9, 5'd4, SLL), 1'b0, "r1 << 4");
		add_entry("srl", enc_r(5'd0, 5'd2, 5'd10, 5'd28, SRL), 1'b0, "r2 >> 28");
		add_entry("andi", enc_i(ANDI, 5'd2, 5'd11, 16'hff0f), 1'b0, "zero extend");
		add_entry("ori", enc_i(ORI, 5'd1, 5'd12, 16'h8000), 1'b0, "zero extend");
		add_entry("xori_stall", enc_i(XORI, 5'd12, 5'd13, 16'hffff), 1'b1, "forward r12");
		add_entry("slti", enc_i(SLTI, 5'd2, 5'd14, 16'hfffe), 1'b0, "-3 < -2");
		add_entry("lui", enc_i(LUI, 5'd0, 5'd15, 16'h1234), 1'b0, "upper half");
		add_entry("write_r0", enc_i(ADDIU, 5'd1, 5'd0, 16'd7), 1'b0, "no retire");
		add_entry("read_r0", enc_r(5'd0, 5'd1, 5'd16, 5'd0, ADDU), 1'b0, "r0 reads 0");
		add_entry("beq_taken", enc_i(BEQ, 5'd1, 5'd1, 16'd3), 1'b0, "taken");
		add_entry("squash_1", enc_i(ADDIU, 5'd0, 5'd17, 16'd99), 1'b0, "never retires");
		add_entry("bne_untaken", enc_i(BNE, 5'd1, 5'd1, 16'd2), 1'b0, "not taken");
		add_entry("after_bne", enc_i(ADDIU, 5'd17, 5'd18, 16'd1), 1'b0, "r17 still 0");
		add_entry("bne_taken", enc_i(BNE, 5'd3, 5'd4, 16'hfffb), 1'b1, "backward");
		add_entry("squash_2", enc_i(ADDIU, 5'd0, 5'd19, 16'd1), 1'b0, "never retires");
		add_entry("beq_untaken", enc_i(BEQ, 5'd1, 5'd2, 16'd1), 1'b0, "not taken");
		add_entry("after_beq", enc_r(5'd18, 5'd18, 5'd20, 5'd0, ADDU), 1'b0, "r18 + r18");
		add_entry("halt", {HALT, 26'h0}, 1'b0, "sets halted");
		add_entry("post_halt_1", enc_i(ADDIU, 5'd0, 5'd21, 16'd7), 1'b0, "ignored");
		add_entry("post_halt_2", enc_r(5'd1, 5'd1, 5'd22, 5'd0, ADDU), 1'b0, "ignored");
	end

	// watchdog
	initial begin
		cycles = 0;
		#1;
		limit = num_entries * 4 + 50;
		while (cycles < limit) begin
			@(posedge CLK);
			cycles++;
		end
		$display("timeout after %0d cycles at entry %0s (%0s)", cycles,
			tbl_name[cur_entry], tbl_note[cur_entry]);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		logic tight;
		nRST        = 1'b0;
		instr       = '0;
		instr_addr  = '0;
		instr_valid = 1'b0;
		stall       = 1'b0;
		cur_name    = '0;
		cur_entry   = 0;
		extra_fail  = 0;
		rng         = 32'd35481;
		tight       = 1'b0;
		repeat (4)
			@(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		for (int i = 0; i < num_entries; i++) begin
			drive_entry(i, tight);
			tight = (tbl_instr[i][31:26] == BEQ) || (tbl_instr[i][31:26] == BNE);
			if (tbl_instr[i][31:26] == HALT) begin
				idle_cycle();
				while (!halted)
					idle_cycle();
			end
		end
		repeat (5)
			idle_cycle();
		if (outstanding != 0) begin
			$display("%0d expected retires never appeared", outstanding);
			extra_fail++;
		end
		$display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt + extra_fail);
		if (fail_cnt == 0 && extra_fail == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: project.f
cpu_pkg.sv
decoder.sv
register_file.sv
pipe_reg.sv
alu.sv
hazard_unit.sv
exec_core.sv
exec_checker.sv
exec_core_props.sv
tb_exec_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' project.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) project.f
	$(VERILATOR) $(VFLAGS) -f project.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
